// ==== dv/chime_input.txt ====
# Columns: command then arguments, frame values in hex as left right
# L cycles | T test_name | F left right | S | B count | W cycles
L 1024
T passthrough_idle
F 00000000 00000000
F 00001234 fffedcba
F 7fffffff 80000000
F 12345678 87654321
W 3
B 8
W 2
T tone_overlay
S
W 20
B 40
W 10
F 00100000 ffe00000
F 00000000 00000000
T saturation
F 7fffffff 80000000
F 7ff00000 80100000
F 7fff0000 8000ffff
F 7fffffff 7fffffff
F 80000000 80000000
B 6
F 80000001 7ffffffe
W 100
T start_while_busy
S
W 300
S
W 1100
T restart_after_done
S
W 1030
B 4

// ==== dv/chime_overlay_assertions.sv ====
`timescale 1ns/1ps

module chime_overlay_assertions (
	input logic clk,
	input logic resetn,
	input logic in_valid,
	input logic out_valid,
	input logic playing,
	input logic done
);

	int valid_fails = 0;
	int done_fails  = 0;
	int pulse_fails = 0;
	int reset_fails = 0;
	int fail_total;

	assign fail_total = valid_fails + done_fails + pulse_fails + reset_fails;

	valid_follows: assert property (@(posedge clk) disable iff (!resetn)
		in_valid |=> out_valid)
	else begin
		valid_fails++;
		$error("out_valid did not rise one cycle after in_valid");
	end

	// Also no output strobe without an input strobe
	valid_quiet: assert property (@(posedge clk) disable iff (!resetn)
		!in_valid |=> !out_valid)
	else begin
		valid_fails++;
		$error("out_valid rose without a preceding in_valid");
	end

	done_on_fall: assert property (@(posedge clk) disable iff (!resetn)
		done == $fell(playing))
	else begin
		done_fails++;
		$error("done does not line up with playing falling");
	end

	done_single: assert property (@(posedge clk) disable iff (!resetn)
		done |=> !done)
	else begin
		pulse_fails++;
		$error("done stayed high longer than one cycle");
	end

	idle_after_reset: assert property (@(posedge clk) !resetn |=> !playing)
	else begin
		reset_fails++;
		$error("playing was high right after reset");
	end

endmodule

bind chime_overlay chime_overlay_assertions i_chime_overlay_assertions (.*);

// ==== dv/chime_overlay_tb.sv ====
`timescale 1ns/1ps

module chime_overlay_tb import chime_pkg::*; ();

	localparam sample_t TONE_LEVEL = 10000000;
	localparam string   CMD_FILE   = "dv/chime_input.txt";

	logic    clk;
	logic    resetn;
	logic    start;
	logic    in_valid;
	stereo_t in_frame;
	logic    out_valid;
	stereo_t out_frame;
	logic    playing;
	logic    done;

	// Commands loaded from the input file
	string   cmd_kind [$];
	int      cmd_arg [$];
	stereo_t cmd_frame [$];
	string   cmd_name [$];

	// Scoreboard of driven frames and the playing flag seen with each
	stereo_t sb_frame [$];
	logic    sb_play [$];

	string current_test = "reset";
	int    play_len = 0;
	int    watchdog_cycles = 0;
	int    remain = 0;
	int    tone_frames = 0;
	logic  done_due = 1'b0;
	logic  prev_in_valid = 1'b0;

	chime_overlay i_chime_overlay (
		.clk       (clk),
		.resetn    (resetn),
		.start     (start),
		.in_valid  (in_valid),
		.in_frame  (in_frame),
		.out_valid (out_valid),
		.out_frame (out_frame),
		.playing   (playing),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_frame(input string what, input stereo_t exp, input stereo_t act);
		if (exp !== act) begin
			fail_run($sformatf("Mismatch in %s: %s expected %h_%h actual %h_%h",
				current_test, what, exp.left, exp.right, act.left, act.right));
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			fail_run($sformatf("Mismatch in %s: %s expected %b actual %b",
				current_test, what, exp, act));
		end
	endtask

	// Sum clamped to the sample range
	function automatic sample_t clamp_sum(input sample_t value, input sample_t offset);
		longint total;
		sample_t result;
		total = longint'(value) + longint'(offset);
		if (total > longint'(SAMPLE_MAX)) begin
			result = SAMPLE_MAX;
		end else if (total < longint'(SAMPLE_MIN)) begin
			result = SAMPLE_MIN;
		end else begin
			result = sample_t'(total);
		end
		return result;
	endfunction

	function automatic stereo_t offset_frame(input stereo_t frame, input sample_t offset);
		stereo_t result;
		result.left  = clamp_sum(frame.left, offset);
		result.right = clamp_sum(frame.right, offset);
		return result;
	endfunction

	// While playing the tone is 0 or plus or minus the level, same on both channels
	task automatic check_output(input stereo_t sent, input logic was_playing, input stereo_t got);
		stereo_t expected;
		sample_t offsets [3];
		int      n_off;
		int      i;
		offsets[0] = '0;
		offsets[1] = TONE_LEVEL;
		offsets[2] = -TONE_LEVEL;
		n_off = was_playing ? 3 : 1;
		expected = offset_frame(sent, offsets[0]);
		for (i = 0; i < n_off; i++) begin
			if (offset_frame(sent, offsets[i]) === got) begin
				expected = offset_frame(sent, offsets[i]);
			end
		end
		compare_frame("out_frame", expected, got);
		// Frames the tone actually moved
		if (expected !== offset_frame(sent, offsets[0])) begin
			tone_frames++;
		end
	endtask

	task automatic load_commands();
		int      fd;
		int      arg;
		string   line;
		string   tok;
		string   name;
		logic [31:0] left;
		logic [31:0] right;
		fd = $fopen(CMD_FILE, "r");
		if (fd == 0) begin
			fail_run("could not open the command file dv/chime_input.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			tok = "";
			if ($fgets(line, fd) != 0 && $sscanf(line, "%s", tok) == 1) begin
				arg = 0;
				name = "";
				left = '0;
				right = '0;
				case (tok)
					"L", "B", "W": void'($sscanf(line, "%s %d", tok, arg));
					"T": void'($sscanf(line, "%s %s", tok, name));
					"F": void'($sscanf(line, "%s %h %h", tok, left, right));
					"S": arg = 0;
					default: begin
						if (tok.substr(0, 0) != "#") begin
							fail_run({"unknown command in input file: ", tok});
						end
					end
				endcase
				if (tok.substr(0, 0) != "#") begin
					cmd_kind.push_back(tok);
					cmd_arg.push_back(arg);
					cmd_frame.push_back({sample_t'(left), sample_t'(right)});
					cmd_name.push_back(name);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_cycle(input logic strobe, input logic valid, input stereo_t frame);
		@(posedge clk);
		start    <= strobe;
		in_valid <= valid;
		in_frame <= frame;
	endtask

	initial begin
		int total;
		int i;
		int n;
		start    <= 1'b0;
		in_valid <= 1'b0;
		in_frame <= '0;
		resetn   <= 1'b0;
		void'($urandom(32'hef3c_bfc9));
		load_commands();
		total = 0;
		for (i = 0; i < cmd_kind.size(); i++) begin
			if (cmd_kind[i] == "L") begin
				play_len = cmd_arg[i];
			end else if (cmd_kind[i] == "W" || cmd_kind[i] == "B") begin
				total += cmd_arg[i];
			end else if (cmd_kind[i] == "F" || cmd_kind[i] == "S") begin
				total += 1;
			end
		end
		watchdog_cycles = 2 * (total + 2 * play_len) + 200;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		for (i = 0; i < cmd_kind.size(); i++) begin
			case (cmd_kind[i])
				"T": current_test = cmd_name[i];
				"F": drive_cycle(1'b0, 1'b1, cmd_frame[i]);
				"S": drive_cycle(1'b1, 1'b0, in_frame);
				"W": repeat (cmd_arg[i]) drive_cycle(1'b0, 1'b0, in_frame);
				"B": begin
					for (n = 0; n < cmd_arg[i]; n++) begin
						drive_cycle(1'b0, 1'b1, {sample_t'($urandom), sample_t'($urandom)});
					end
				end
				default: ;
			endcase
		end
		current_test = "drain";
		drive_cycle(1'b0, 1'b0, in_frame);
		while (sb_frame.size() != 0 || playing || remain != 0) begin
			drive_cycle(1'b0, 1'b0, in_frame);
		end
		repeat (3) drive_cycle(1'b0, 1'b0, in_frame);
		if (i_chime_overlay.i_chime_overlay_assertions.fail_total != 0) begin
			fail_run("a bound assertion failed");
		end else if (tone_frames == 0) begin
			fail_run("no output frame during playback carried the tone");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		fail_run("run hung: the tests did not finish within the cycle limit");
	end

	// Outputs are checked at the falling edge where they are stable
	always @(negedge clk) begin
		if (resetn) begin
			if (i_chime_overlay.i_chime_overlay_assertions.fail_total != 0) begin
				fail_run("a bound assertion failed");
			end
			compare_bit("out_valid", prev_in_valid, out_valid);
			if (out_valid) begin
				if (sb_frame.size() == 0) begin
					fail_run("an output frame arrived with no input frame pending");
				end else begin
					check_output(sb_frame.pop_front(), sb_play.pop_front(), out_frame);
				end
			end
			compare_bit("playing", remain > 0, playing);
			compare_bit("done", done_due, done);
			if (in_valid) begin
				sb_frame.push_back(in_frame);
				sb_play.push_back(playing);
			end
			prev_in_valid = in_valid;
			// Start only counts while playback is off
			done_due = (remain == 1);
			if (remain > 0) begin
				remain--;
			end else if (start) begin
				remain = play_len;
			end
		end
	end

endmodule

// ==== flist.f ====
logic/chime_pkg.sv
logic/chime_rom.sv
logic/chime_sequencer.sv
logic/tone_generator.sv
logic/sample_mixer.sv
logic/chime_overlay.sv
dv/chime_overlay_assertions.sv
dv/chime_overlay_tb.sv

// ==== logic/chime_overlay.sv ====
`timescale 1ns/1ps

module chime_overlay import chime_pkg::*; #(
	parameter int      NUM_NOTES   = 16,
	parameter int      NOTE_CYCLES = 64,
	parameter int      BASE_HALF   = 4,
	parameter int      HALF_STEP   = 2,
	parameter sample_t TONE_LEVEL  = 10000000
) (
	input  logic    clk,
	input  logic    resetn,
	input  logic    start,
	input  logic    in_valid,
	input  stereo_t in_frame,
	output logic    out_valid,
	output stereo_t out_frame,
	output logic    playing,
	output logic    done
);

	localparam int ADDR_W = $clog2(NUM_NOTES);

	logic [ADDR_W-1:0] address;
	pitch_t            pitch;
	sample_t           tone;

	chime_sequencer #(
		.NUM_NOTES   (NUM_NOTES),
		.NOTE_CYCLES (NOTE_CYCLES)
	) i_chime_sequencer (
		.clk     (clk),
		.resetn  (resetn),
		.start   (start),
		.playing (playing),
		.done    (done),
		.address (address)
	);

	chime_rom #(
		.NUM_NOTES (NUM_NOTES)
	) i_chime_rom (
		.clk     (clk),
		.address (address),
		.pitch   (pitch)
	);

	// Silent whenever the sequencer is not playing
	tone_generator #(
		.BASE_HALF  (BASE_HALF),
		.HALF_STEP  (HALF_STEP),
		.TONE_LEVEL (TONE_LEVEL)
	) i_tone_generator (
		.clk     (clk),
		.resetn  (resetn),
		.playing (playing),
		.pitch   (pitch),
		.tone    (tone)
	);

	sample_mixer i_sample_mixer (
		.clk       (clk),
		.resetn    (resetn),
		.in_valid  (in_valid),
		.in_frame  (in_frame),
		.tone      (tone),
		.out_valid (out_valid),
		.out_frame (out_frame)
	);

endmodule

// ==== logic/chime_pkg.sv ====
package chime_pkg;

	// One codec sample, signed two's complement
	typedef logic signed [31:0] sample_t;

	// Left and right samples of one frame
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Tune pitch code, 0 is a rest
	typedef logic [2:0] pitch_t;

	// Saturation limits
	localparam sample_t SAMPLE_MAX = {1'b0, {($bits(sample_t) - 1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {($bits(sample_t) - 1){1'b0}}};

	// Playback status of the sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE   = 2'd0,
		SEQ_PLAY   = 2'd1,
		SEQ_FINISH = 2'd2
	} seq_state_t;

endpackage

// ==== logic/chime_rom.sv ====
`timescale 1ns/1ps

module chime_rom import chime_pkg::*; #(
	parameter int NUM_NOTES = 16
) (
	input  logic                         clk,
	input  logic [$clog2(NUM_NOTES)-1:0] address,
	output pitch_t                       pitch
);

	pitch_t table_pitch;

	// Tune table, rests marked by code 0
	always_comb begin
		case (address)
			0:       table_pitch = 3'd1;
			1:       table_pitch = 3'd3;
			2:       table_pitch = 3'd5;
			3:       table_pitch = 3'd0;
			4:       table_pitch = 3'd5;
			5:       table_pitch = 3'd3;
			6:       table_pitch = 3'd1;
			7:       table_pitch = 3'd0;
			8:       table_pitch = 3'd2;
			9:       table_pitch = 3'd4;
			10:      table_pitch = 3'd6;
			11:      table_pitch = 3'd7;
			12:      table_pitch = 3'd6;
			13:      table_pitch = 3'd4;
			14:      table_pitch = 3'd2;
			15:      table_pitch = 3'd0;
			default: table_pitch = 3'd0;
		endcase
	end

	// Synchronous read, one cycle behind the address
	always_ff @(posedge clk) begin
		pitch <= table_pitch;
	end

endmodule

// ==== logic/chime_sequencer.sv ====
`timescale 1ns/1ps

module chime_sequencer import chime_pkg::*; #(
	parameter int NUM_NOTES   = 16,
	parameter int NOTE_CYCLES = 64
) (
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         start,
	output logic                         playing,
	output logic                         done,
	output logic [$clog2(NUM_NOTES)-1:0] address
);

	localparam int ADDR_W = $clog2(NUM_NOTES);
	localparam int CNT_W  = (NOTE_CYCLES > 1) ? $clog2(NOTE_CYCLES) : 1;

	seq_state_t       state;
	logic [CNT_W-1:0] note_cnt;
	logic             note_end;
	logic             last_note;

	assign note_end  = (note_cnt == CNT_W'(NOTE_CYCLES - 1));
	assign last_note = (address == ADDR_W'(NUM_NOTES - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= SEQ_IDLE;
			address  <= '0;
			note_cnt <= '0;
		end else begin
			case (state)
				// Finish also takes a start, playing is already low there
				SEQ_IDLE, SEQ_FINISH: begin
					address  <= '0;
					note_cnt <= '0;
					if (start) begin
						state <= SEQ_PLAY;
					end else begin
						state <= SEQ_IDLE;
					end
				end
				SEQ_PLAY: begin
					if (note_end) begin
						note_cnt <= '0;
						if (last_note) begin
							// Park on note 0 so the ROM is ready for the next start
							address <= '0;
							state   <= SEQ_FINISH;
						end else begin
							address <= address + 1'b1;
						end
					end else begin
						note_cnt <= note_cnt + 1'b1;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	assign playing = (state == SEQ_PLAY);
	assign done    = (state == SEQ_FINISH);

endmodule

// ==== logic/sample_mixer.sv ====
`timescale 1ns/1ps

module sample_mixer import chime_pkg::*; (
	input  logic    clk,
	input  logic    resetn,
	input  logic    in_valid,
	input  stereo_t in_frame,
	input  sample_t tone,
	output logic    out_valid,
	output stereo_t out_frame
);

	localparam int SAMPLE_W = $bits(sample_t);

	// One guard bit above the sample width
	typedef logic signed [SAMPLE_W:0] wide_t;

	wide_t   sum_left;
	wide_t   sum_right;
	stereo_t mixed;

	function automatic sample_t saturate(input wide_t value);
		sample_t result;
		// Top two bits differ only on overflow
		if (value[SAMPLE_W] != value[SAMPLE_W-1]) begin
			result = value[SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
		end else begin
			result = value[SAMPLE_W-1:0];
		end
		return result;
	endfunction

	assign sum_left  = wide_t'(in_frame.left) + wide_t'(tone);
	assign sum_right = wide_t'(in_frame.right) + wide_t'(tone);

	always_comb begin
		mixed.left  = saturate(sum_left);
		mixed.right = saturate(sum_right);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Frame only changes on a sample strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_frame <= mixed;
		end
	end

endmodule

// ==== logic/tone_generator.sv ====
`timescale 1ns/1ps

module tone_generator import chime_pkg::*; #(
	parameter int      BASE_HALF  = 4,
	parameter int      HALF_STEP  = 2,
	parameter sample_t TONE_LEVEL = 10000000
) (
	input  logic    clk,
	input  logic    resetn,
	input  logic    playing,
	input  pitch_t  pitch,
	output sample_t tone
);

	localparam int PITCH_TOP = 2 ** $bits(pitch_t) - 1;
	localparam int MAX_HALF  = BASE_HALF + PITCH_TOP * HALF_STEP;
	localparam int CNT_W     = (MAX_HALF > 1) ? $clog2(MAX_HALF + 1) : 1;

	logic [CNT_W-1:0] half_len;
	logic [CNT_W-1:0] half_cnt;
	logic             phase;
	pitch_t           last_pitch;
	logic             restart;

	// Cycles per half period for the current code
	assign half_len = CNT_W'(BASE_HALF) + CNT_W'(pitch) * CNT_W'(HALF_STEP);

	assign restart = !playing || (pitch != last_pitch);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			half_cnt   <= '0;
			phase      <= 1'b1;
			last_pitch <= '0;
		end else begin
			last_pitch <= pitch;
			if (restart) begin
				// New note starts in the high phase
				half_cnt <= half_len - 1'b1;
				phase    <= 1'b1;
			end else if (half_cnt == '0) begin
				half_cnt <= half_len - 1'b1;
				phase    <= ~phase;
			end else begin
				half_cnt <= half_cnt - 1'b1;
			end
		end
	end

	always_comb begin
		if (!playing || pitch == '0) begin
			tone = '0;
		end else if (phase) begin
			tone = TONE_LEVEL;
		end else begin
			tone = -TONE_LEVEL;
		end
	end

endmodule
